//--- noc_traffic_top.f
+incdir+.
noc_pkg.sv
sequential_traffic_generator.sv
gaussian_traffic_generator.sv
shared_bus_network.sv
delivery_counters.sv
noc_traffic_top.sv
noc_traffic_assert.sv
tb_noc_traffic.sv

//--- Bender.yml
package:
  name: noc_traffic

sources:
  - include_dirs:
      - .
    files:
      - noc_pkg.sv
      - sequential_traffic_generator.sv
      - gaussian_traffic_generator.sv
      - shared_bus_network.sv
      - delivery_counters.sv
      - noc_traffic_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - noc_traffic_assert.sv
      - tb_noc_traffic.sv

//--- tb_noc_traffic.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module tb_noc_traffic import noc_pkg::*; ();
    localparam int NODES = `NOC_NODE_COUNT;

    logic             clk;
    logic             rst;
    payload_t         seq_payload [NODES];
    logic [3:0][31:0] gauss_seed [NODES];
    logic             deliver_valid;
    flit_t            deliver;
    count_t           drops [NODES];
    count_t           rx_count [NODES];
    count_t           rx_total;

    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;

    // scoreboard kept by the delivery monitor.
    packet_id_t last_id [NODES];
    node_t      last_dest [NODES];  // expected destination model for even nodes.
    int         src_count [NODES];
    int         dest_count [NODES];
    payload_t   pay_cur [NODES];
    payload_t   pay_prev [NODES];
    logic       old_ok [NODES];     // one packet may still carry the old payload.
    logic       saw_new [NODES];
    logic       balanced [NODES];

    noc_traffic_top noc_traffic_top_inst (
        .clk          (clk),
        .rst          (rst),
        .seq_payload  (seq_payload),
        .gauss_seed   (gauss_seed),
        .deliver_valid(deliver_valid),
        .deliver      (deliver),
        .drops        (drops),
        .rx_count     (rx_count),
        .rx_total     (rx_total)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers and the destination model.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0]; // one step per bit.
        end
    endtask

    function automatic node_t first_dest(input int src);
        for (int n = 0; n < NODES; n++) begin
            if (n != src) begin
                return node_t'(n);
            end
        end
        return '0;
    endfunction

    function automatic node_t following_dest(input int src, input node_t d);
        int n;
        n = (int'(d) + 1) % NODES;
        if (n == src) begin
            n = (n + 1) % NODES;
        end
        return node_t'(n);
    endfunction

    task automatic check_payload(input string name, input payload_t got, input payload_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_node(input string name, input node_t got, input node_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_id(input string name, input packet_id_t got, input packet_id_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_src_count(input int src, input int target, input int limit);
        int cycles;
        cycles = 0;
        while (src_count[src] < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (src_count[src] < target) begin
            $display("timed out waiting for %0d deliveries from node %0d", target, src);
            other_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // delivery monitor. reads the bus as it was during the closing cycle.
    always @(posedge clk) begin : delivery_monitor
        int    s;
        int    d;
        node_t exp_dest;
        if (!rst && deliver_valid) begin
            s = int'(deliver.src);
            d = int'(deliver.dest);
            if (s == d || d >= NODES) begin
                $display("flit from node %0d was delivered to illegal node %0d", s, d);
                other_errors++;
            end
            if (s % 2 == 0) begin
                check_id($sformatf("id from node %0d", s), deliver.id,
                         packet_id_t'(last_id[s] + 1));
                exp_dest = (src_count[s] == 0) ? first_dest(s) : following_dest(s, last_dest[s]);
                check_node($sformatf("dest from node %0d", s), deliver.dest, exp_dest);
                last_dest[s] = exp_dest;
                if (old_ok[s] && deliver.payload === pay_prev[s]) begin
                    old_ok[s] = 1'b0; // generated before the change.
                end else begin
                    check_payload($sformatf("payload from node %0d", s), deliver.payload,
                                  pay_cur[s]);
                    old_ok[s] = 1'b0;
                    saw_new[s] = (deliver.payload === pay_cur[s]);
                end
            end else begin
                if (deliver.id <= last_id[s]) begin
                    $display("node %0d delivered id %0d after id %0d", s, deliver.id, last_id[s]);
                    other_errors++;
                end
                // every id below this one was either delivered or dropped.
                if (src_count[s] + 1 + int'(drops[s]) < int'(deliver.id)) begin
                    $display("node %0d lost packets that were not counted as drops", s);
                    other_errors++;
                end
                if (src_count[s] + 1 + int'(drops[s]) == int'(deliver.id)) begin
                    balanced[s] = 1'b1;
                end
            end
            last_id[s] = deliver.id;
            src_count[s]++;
            if (d < NODES) begin
                dest_count[d]++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    task automatic reset_test();
        int cycles;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!deliver_valid && cycles < 100) begin
            for (int i = 0; i < NODES; i++) begin
                check_count($sformatf("drops[%0d]", i), drops[i], '0);
                check_count($sformatf("rx_count[%0d]", i), rx_count[i], '0);
            end
            check_count("rx_total", rx_total, '0);
            @(negedge clk);
            cycles++;
        end
        if (!deliver_valid) begin
            $display("no delivery appeared after reset");
            other_errors++;
        end
    endtask

    task automatic sequential_order_test();
        for (int i = 0; i < NODES; i += 2) begin
            wait_src_count(i, src_count[i] + 4, 200);
        end
    endtask

    task automatic payload_change_test();
        logic [31:0] w;
        @(negedge clk);
        for (int i = 0; i < NODES; i += 2) begin
            draw_word(w);
            pay_prev[i] = pay_cur[i];
            pay_cur[i] = w;
            old_ok[i] = 1'b1;
            saw_new[i] = 1'b0;
            seq_payload[i] = w;
        end
        for (int i = 0; i < NODES; i += 2) begin
            wait_src_count(i, src_count[i] + 2, 200);
            if (!saw_new[i]) begin
                $display("node %0d never delivered its changed payload", i);
                other_errors++;
            end
        end
    endtask

    task automatic gaussian_loss_test();
        int   cycles;
        logic done;
        for (int i = 1; i < NODES; i += 2) begin
            balanced[i] = 1'b0;
        end
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < 400) begin
            @(negedge clk);
            cycles++;
            done = 1'b1;
            for (int i = 1; i < NODES; i += 2) begin
                if (!balanced[i]) begin
                    done = 1'b0;
                end
            end
        end
        for (int i = 1; i < NODES; i += 2) begin
            if (!balanced[i]) begin
                $display("delivered plus dropped never matched the last id of node %0d", i);
                other_errors++;
            end
        end
    endtask

    task automatic counter_test();
        int sum;
        repeat (40) @(negedge clk);
        sum = 0;
        for (int i = 0; i < NODES; i++) begin
            check_count($sformatf("rx_count[%0d]", i), rx_count[i], count_t'(dest_count[i]));
            sum += dest_count[i];
        end
        check_count("rx_total", rx_total, count_t'(sum));
        if (sum == 0) begin
            $display("no packets were delivered at all");
            other_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lfsr_state = 32'h8619;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < NODES; i++) begin
            for (int k = 0; k < 4; k++) begin
                draw_word(gauss_seed[i][k]);
                if (gauss_seed[i][k] == '0) begin
                    gauss_seed[i][k] = 32'h1; // an all-zero LFSR never moves.
                end
            end
            draw_word(seq_payload[i]);
            pay_cur[i] = seq_payload[i];
            pay_prev[i] = seq_payload[i];
            last_id[i] = '0;
            last_dest[i] = '0;
            src_count[i] = 0;
            dest_count[i] = 0;
            old_ok[i] = 1'b0;
            saw_new[i] = 1'b0;
            balanced[i] = 1'b0;
        end

        reset_test();
        sequential_order_test();
        payload_change_test();
        gaussian_loss_test();
        counter_test();

        $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 noc_traffic_top_inst.shared_bus_network_inst.noc_traffic_assert_inst.assert_fails);
        if (value_errors + other_errors
            + noc_traffic_top_inst.shared_bus_network_inst.noc_traffic_assert_inst.assert_fails
            == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- noc_traffic_assert.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module noc_traffic_assert import noc_pkg::*; (
    input logic                       clk,
    input logic                       rst,
    input logic [`NOC_NODE_COUNT-1:0] busy,
    input logic                       deliver_valid,
    input flit_t                      deliver
);
    localparam int NODES = `NOC_NODE_COUNT;

    int assert_fails = 0; // read by the testbench for its closing report.

    // a packet is never looped back to the node that sent it.
    no_self_delivery: assert property (
        @(posedge clk) disable iff (rst)
        deliver_valid |-> deliver.src != deliver.dest
    ) else begin
        assert_fails++;
        $error("delivered flit has the same source and destination");
    end

    dest_in_range: assert property (
        @(posedge clk) disable iff (rst)
        deliver_valid |-> int'(deliver.dest) < NODES
    ) else begin
        assert_fails++;
        $error("delivered flit addresses a node that does not exist");
    end

    // a slot only empties when its own flit goes out on the bus.
    for (genvar i = 0; i < NODES; i++) begin : g_slot
        busy_falls_on_delivery: assert property (
            @(posedge clk) disable iff (rst)
            $fell(busy[i]) |-> deliver_valid && deliver.src == node_t'(i)
        ) else begin
            assert_fails++;
            $error("slot %0d emptied without delivering its flit", i);
        end
    end

endmodule

bind shared_bus_network noc_traffic_assert noc_traffic_assert_inst (
    .clk          (clk),
    .rst          (rst),
    .busy         (busy),
    .deliver_valid(deliver_valid),
    .deliver      (deliver)
);

//--- noc_traffic_top.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module noc_traffic_top import noc_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  payload_t         seq_payload [`NOC_NODE_COUNT], // even nodes only.
    input  logic [3:0][31:0] gauss_seed [`NOC_NODE_COUNT],  // odd nodes only.
    output logic             deliver_valid,
    output flit_t            deliver,
    output count_t           drops [`NOC_NODE_COUNT],
    output count_t           rx_count [`NOC_NODE_COUNT],
    output count_t           rx_total
);
    localparam int NODES = `NOC_NODE_COUNT;

    logic [NODES-1:0] inj_valid;
    flit_t            inj [NODES];
    logic [NODES-1:0] busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // traffic sources, the kind picked by node parity.
    for (genvar i = 0; i < NODES; i++) begin : g_node
        if (i % 2 == 0) begin : g_seq
            sequential_traffic_generator #(
                .NODE_ID(i)
            ) sequential_traffic_generator_inst (
                .clk       (clk),
                .rst       (rst),
                .busy      (busy[i]),
                .payload_in(seq_payload[i]),
                .valid     (inj_valid[i]),
                .flit      (inj[i])
            );
        end else begin : g_gauss
            gaussian_traffic_generator #(
                .NODE_ID(i)
            ) gaussian_traffic_generator_inst (
                .clk  (clk),
                .rst  (rst),
                .seed (gauss_seed[i]),
                .valid(inj_valid[i]),
                .flit (inj[i])
            );
        end
    end

    shared_bus_network shared_bus_network_inst (
        .clk          (clk),
        .rst          (rst),
        .inj_valid    (inj_valid),
        .inj          (inj),
        .busy         (busy),
        .drops        (drops),
        .deliver_valid(deliver_valid),
        .deliver      (deliver)
    );

    delivery_counters delivery_counters_inst (
        .clk          (clk),
        .rst          (rst),
        .deliver_valid(deliver_valid),
        .deliver      (deliver),
        .rx_count     (rx_count),
        .rx_total     (rx_total)
    );

endmodule

//--- delivery_counters.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module delivery_counters import noc_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   deliver_valid,
    input  flit_t  deliver,
    output count_t rx_count [`NOC_NODE_COUNT],
    output count_t rx_total
);
    localparam int NODES = `NOC_NODE_COUNT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_total <= '0;
            for (int i = 0; i < NODES; i++) begin
                rx_count[i] <= '0;
            end
        end else if (deliver_valid) begin
            if (rx_total != '1) begin
                rx_total <= rx_total + 1'b1;
            end
            for (int i = 0; i < NODES; i++) begin
                // only the addressed node counts, and it sticks at the top.
                if (deliver.dest == node_t'(i) && rx_count[i] != '1) begin
                    rx_count[i] <= rx_count[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- shared_bus_network.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module shared_bus_network import noc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`NOC_NODE_COUNT-1:0] inj_valid,
    input  flit_t                      inj [`NOC_NODE_COUNT],
    output logic [`NOC_NODE_COUNT-1:0] busy,
    output count_t                     drops [`NOC_NODE_COUNT],
    output logic                       deliver_valid,
    output flit_t                      deliver
);
    localparam int NODES = `NOC_NODE_COUNT;

    typedef enum logic {
        IDLE,
        SENDING
    } bus_state_t;

    bus_state_t       state;
    flit_t            slot [NODES];
    logic [NODES-1:0] slot_full;
    node_t            rr_ptr;
    node_t            grant_idx;
    logic             grant_any;

    assign busy = slot_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one-entry injection slot per node.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_full <= '0;
            for (int i = 0; i < NODES; i++) begin
                drops[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NODES; i++) begin
                if (inj_valid[i] && !slot_full[i]) begin
                    slot_full[i] <= 1'b1;
                end else if (grant_any && grant_idx == node_t'(i)) begin
                    slot_full[i] <= 1'b0;
                end
                // a strobe into an occupied slot is lost.
                if (inj_valid[i] && slot_full[i] && drops[i] != '1) begin
                    drops[i] <= drops[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NODES; i++) begin
            if (inj_valid[i] && !slot_full[i]) begin
                slot[i] <= inj[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round-robin arbiter. first full slot at or after the pointer wins.
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int off = 0; off < NODES; off++) begin
            idx = (int'(rr_ptr) + off) % NODES;
            if (!grant_any && slot_full[idx]) begin
                grant_any = 1'b1;
                grant_idx = node_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            rr_ptr <= '0;
        end else begin
            state <= grant_any ? SENDING : IDLE; // a grant puts a flit on the bus next cycle.
            if (grant_any) begin
                rr_ptr <= node_t'((int'(grant_idx) + 1) % NODES); // past the winner.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered delivery bus.
    always_ff @(posedge clk) begin
        if (grant_any) begin
            deliver <= slot[grant_idx];
        end
    end

    assign deliver_valid = (state == SENDING);

endmodule

//--- gaussian_traffic_generator.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module gaussian_traffic_generator import noc_pkg::*; #(
    parameter int NODE_ID = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0][31:0] seed,
    output logic        valid,
    output flit_t       flit
);
    localparam int NODES = `NOC_NODE_COUNT;
    localparam int LN2   = `NOC_LN2_PERIOD;

    // feedback tap of each generator, next to bit 31.
    localparam int TAP [4] = '{21, 25, 18, 14};

    logic [31:0]     lfsr [4];
    logic [LN2-1:0]  sample;
    logic [33:0]     lfsr_sum;
    payload_t        avg;
    node_t           rand_dest;
    packet_id_t      id;

    assign lfsr_sum = 34'(lfsr[0]) + 34'(lfsr[1]) + 34'(lfsr[2]) + 34'(lfsr[3]);

    always_comb begin
        int unsigned raw;
        raw = lfsr[0] % NODES;
        if (raw == NODE_ID) begin
            raw = (raw + 1) % NODES; // never send to ourselves.
        end
        rand_dest = node_t'(raw);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // free-running LFSRs, trigger sample and packet counter.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                lfsr[k] <= seed[k];
            end
            sample <= '1; // no packet straight out of reset.
            valid  <= 1'b0;
            id     <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                lfsr[k] <= {lfsr[k][30:0], lfsr[k][31] ^ lfsr[k][TAP[k]]};
            end
            sample <= lfsr[0][LN2-1:0];
            valid  <= (sample == '0);
            if (sample == '0) begin
                id <= id + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload path. the sum of four roughly uniform values is near bell shaped.
    always_ff @(posedge clk) begin
        avg <= lfsr_sum[33:2];
        if (sample == '0) begin
            flit.payload <= avg;
            flit.src     <= node_t'(NODE_ID);
            flit.dest    <= rand_dest;
            flit.id      <= id + 1'b1;
        end
    end

endmodule

//--- sequential_traffic_generator.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

module sequential_traffic_generator import noc_pkg::*; #(
    parameter int NODE_ID = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     busy,
    input  payload_t payload_in,
    output logic     valid,
    output flit_t    flit
);
    localparam int NODES = `NOC_NODE_COUNT;
    localparam int GAP_W = (`NOC_SEQ_GAP > 1) ? $clog2(`NOC_SEQ_GAP) : 1;

    logic [GAP_W-1:0] gap_cnt;
    logic             fire;
    node_t            cur_dest;
    node_t            next_dest;
    packet_id_t       id;

    assign fire = !busy && (gap_cnt == GAP_W'(`NOC_SEQ_GAP - 1));

    // step to the next node and jump over our own index.
    always_comb begin
        int nxt;
        nxt = (int'(cur_dest) + 1) % NODES;
        if (nxt == NODE_ID) begin
            nxt = (nxt + 1) % NODES;
        end
        next_dest = node_t'(nxt);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid    <= 1'b0;
            gap_cnt  <= '0;
            id       <= '0;
            cur_dest <= (NODE_ID == 0) ? node_t'(1) : node_t'(0);
        end else begin
            valid <= fire;
            if (fire) begin
                gap_cnt  <= '0;
                id       <= id + 1'b1;
                cur_dest <= next_dest;
            end else if (!busy) begin
                gap_cnt <= gap_cnt + 1'b1; // frozen while the slot is occupied.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            flit.payload <= payload_in;
            flit.src     <= node_t'(NODE_ID);
            flit.dest    <= cur_dest;
            flit.id      <= id + 1'b1;
        end
    end

endmodule

//--- noc_pkg.sv
`include "noc_settings.svh"

package noc_pkg;

    typedef logic [$clog2(`NOC_NODE_COUNT)-1:0] node_t;      // node index.
    typedef logic [`NOC_ID_WIDTH-1:0]            packet_id_t; // per-source sequence number.
    typedef logic [31:0]                         payload_t;
    typedef logic [15:0]                         count_t;     // saturating event counter.

    // one single-flit packet as it travels over the bus.
    typedef struct packed {
        payload_t   payload;
        node_t      src;
        node_t      dest;
        packet_id_t id;
    } flit_t;

endpackage

//--- noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// number of nodes on the shared bus.
`define NOC_NODE_COUNT 4

// width of the per-source packet sequence number.
`define NOC_ID_WIDTH 8

// a gaussian packet is sent when this many low LFSR bits are all zero.
`define NOC_LN2_PERIOD 2

// free cycles a sequential generator waits between two packets.
`define NOC_SEQ_GAP 8

`endif
